// File: muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // Instruction field types
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  reg_addr_t;

    // Register-register major opcode
    localparam opcode_t OPCODE_OP = 7'b0110011;

    // funct7 marking the M extension
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    // Encodings follow funct3 directly
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_BUSY = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_BUSY = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

// File: muldiv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_decode
    import muldiv_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  instr_t            instr,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   rs2_data,
    output muldiv_op_e        op,
    output logic              is_illegal,
    output logic              mul_req,
    output logic              div_req,
    output logic              sign_invert,
    output logic [XLEN-1:0]   op_a,
    output logic [XLEN-1:0]   op_b,
    output logic [XLEN-1:0]   rs1_raw
);

    opcode_t         opcode;
    funct3_t         funct3;
    funct7_t         funct7;
    logic            is_m;
    logic            rs1_neg;
    logic            rs2_neg;
    logic [XLEN-1:0] rs1_mag;
    logic [XLEN-1:0] rs2_mag;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign is_m       = (opcode == OPCODE_OP) && (funct7 == FUNCT7_MULDIV);
    assign is_illegal = !is_m;
    assign op         = muldiv_op_e'(funct3);

    // funct3[2] splits multiply from divide
    assign mul_req = is_m && !funct3[2];
    assign div_req = is_m && funct3[2];

    assign rs1_raw = rs1_data;

    assign rs1_neg = rs1_data[XLEN-1];
    assign rs2_neg = rs2_data[XLEN-1];
    assign rs1_mag = rs1_neg ? -rs1_data : rs1_data;
    assign rs2_mag = rs2_neg ? -rs2_data : rs2_data;

    // Operand magnitudes and result sign rule per operation
    always_comb begin
        case (op)
            OP_MUL, OP_MULH, OP_DIV: begin
                op_a        = rs1_mag;
                op_b        = rs2_mag;
                sign_invert = rs1_neg ^ rs2_neg;
            end
            OP_REM: begin
                op_a        = rs1_mag;
                op_b        = rs2_mag;
                sign_invert = rs1_neg;
            end
            OP_MULHSU: begin
                op_a        = rs1_mag;
                op_b        = rs2_data;
                sign_invert = rs1_neg;
            end
            default: begin
                // MULHU, DIVU, REMU
                op_a        = rs1_data;
                op_b        = rs2_data;
                sign_invert = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: seq_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module seq_multiplier
    import muldiv_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mul_req,
    input  logic [XLEN-1:0]   op_a,
    input  logic [XLEN-1:0]   op_b,
    output logic              mul_ready,
    output logic [2*XLEN-1:0] product
);

    localparam int CNT_W = $clog2(XLEN);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(XLEN - 1);

    mul_state_e        state;
    logic [CNT_W-1:0]  iter;
    logic [XLEN-1:0]   mcand;
    // Upper half accumulates, lower half holds the shifting multiplier
    logic [2*XLEN-1:0] acc;
    logic [XLEN:0]     step_sum;
    logic              start;

    assign start = (state == MUL_IDLE) && mul_req;

    assign step_sum = {1'b0, acc[2*XLEN-1:XLEN]}
                    + (acc[0] ? {1'b0, mcand} : {(XLEN+1){1'b0}});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MUL_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (mul_req) begin
                        state <= MUL_BUSY;
                        iter  <= '0;
                    end
                end
                MUL_BUSY: begin
                    iter <= iter + 1'b1;
                    if (iter == LAST_ITER) begin
                        state <= MUL_DONE;
                    end
                end
                MUL_DONE: state <= MUL_IDLE;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= op_a;
            acc   <= {{XLEN{1'b0}}, op_b};
        end else if (state == MUL_BUSY) begin
            acc <= {step_sum, acc[XLEN-1:1]};
        end
    end

    assign mul_ready = (state == MUL_DONE);
    assign product   = acc;

endmodule

`default_nettype wire

// File: seq_divider.sv
`timescale 1ns/100ps
`default_nettype none

module seq_divider
    import muldiv_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            div_req,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic            div_ready,
    output logic            div_by_zero,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    localparam int CNT_W = $clog2(XLEN);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(XLEN - 1);

    div_state_e       state;
    logic [CNT_W-1:0] iter;
    logic             zero_flag;
    logic [XLEN-1:0]  divisor;
    // Dividend bits shift out the top while quotient bits enter the bottom
    logic [XLEN-1:0]  quo;
    logic [XLEN-1:0]  rem;
    logic [XLEN:0]    trial;
    logic [XLEN:0]    diff;
    logic             start;
    logic             divisor_zero;

    assign start        = (state == DIV_IDLE) && div_req;
    assign divisor_zero = (op_b == '0);

    assign trial = {rem, quo[XLEN-1]};
    assign diff  = trial - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= DIV_IDLE;
            iter      <= '0;
            zero_flag <= 1'b0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (div_req) begin
                        zero_flag <= divisor_zero;
                        iter      <= '0;
                        // Zero divisor needs no iterations
                        state     <= divisor_zero ? DIV_DONE : DIV_BUSY;
                    end
                end
                DIV_BUSY: begin
                    iter <= iter + 1'b1;
                    if (iter == LAST_ITER) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: state <= DIV_IDLE;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= op_b;
            quo     <= op_a;
            rem     <= '0;
        end else if (state == DIV_BUSY) begin
            // Restore when the trial subtraction goes negative
            rem <= diff[XLEN] ? trial[XLEN-1:0] : diff[XLEN-1:0];
            quo <= {quo[XLEN-2:0], ~diff[XLEN]};
        end
    end

    assign div_ready   = (state == DIV_DONE);
    assign div_by_zero = zero_flag;
    assign quotient    = quo;
    assign remainder   = rem;

endmodule

`default_nettype wire

// File: muldiv_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_writeback
    import muldiv_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  instr_t            instr,
    input  muldiv_op_e        op,
    input  logic              is_illegal,
    input  logic              sign_invert,
    input  logic [XLEN-1:0]   rs1_raw,
    input  logic              mul_ready,
    input  logic [2*XLEN-1:0] product,
    input  logic              div_ready,
    input  logic              div_by_zero,
    input  logic [XLEN-1:0]   quotient,
    input  logic [XLEN-1:0]   remainder,
    output logic              ready,
    output logic              illegal,
    output reg_addr_t         rd_addr,
    output logic [XLEN-1:0]   rd_wdata,
    output logic              rd_write
);

    logic              is_div_class;
    logic              unit_ready;
    logic [2*XLEN-1:0] product_fix;
    logic [XLEN-1:0]   quotient_fix;
    logic [XLEN-1:0]   remainder_fix;

    assign rd_addr = instr[11:7];

    assign is_div_class = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign unit_ready   = is_div_class ? div_ready : mul_ready;

    // Illegal words complete in the cycle they appear
    assign ready   = is_illegal || unit_ready;
    assign illegal = is_illegal;

    // High half needs the full-width negation
    assign product_fix   = sign_invert ? -product : product;
    assign quotient_fix  = sign_invert ? -quotient : quotient;
    assign remainder_fix = sign_invert ? -remainder : remainder;

    always_comb begin
        case (op)
            OP_MUL: begin
                rd_wdata = product_fix[XLEN-1:0];
            end
            OP_MULH, OP_MULHSU, OP_MULHU: begin
                rd_wdata = product_fix[2*XLEN-1:XLEN];
            end
            OP_DIV, OP_DIVU: begin
                // All ones on divide by zero
                rd_wdata = div_by_zero ? {XLEN{1'b1}} : quotient_fix;
            end
            default: begin
                // REM, REMU return the dividend on divide by zero
                rd_wdata = div_by_zero ? rs1_raw : remainder_fix;
            end
        endcase
    end

    assign rd_write = ready && !is_illegal && (rd_addr != '0);

endmodule

`default_nettype wire

// File: muldiv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_execute
    import muldiv_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  instr_t          instr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            ready,
    output logic            illegal,
    output reg_addr_t       rd_addr,
    output logic [XLEN-1:0] rd_wdata,
    output logic            rd_write
);

    muldiv_op_e        op;
    logic              is_illegal;
    logic              mul_req;
    logic              div_req;
    logic              sign_invert;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   rs1_raw;
    logic              mul_ready;
    logic [2*XLEN-1:0] product;
    logic              div_ready;
    logic              div_by_zero;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;

    muldiv_decode #(.XLEN(XLEN)) u_decode (
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .op          (op),
        .is_illegal  (is_illegal),
        .mul_req     (mul_req),
        .div_req     (div_req),
        .sign_invert (sign_invert),
        .op_a        (op_a),
        .op_b        (op_b),
        .rs1_raw     (rs1_raw)
    );

    seq_multiplier #(.XLEN(XLEN)) u_multiplier (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_req   (mul_req),
        .op_a      (op_a),
        .op_b      (op_b),
        .mul_ready (mul_ready),
        .product   (product)
    );

    seq_divider #(.XLEN(XLEN)) u_divider (
        .clk         (clk),
        .rst_n       (rst_n),
        .div_req     (div_req),
        .op_a        (op_a),
        .op_b        (op_b),
        .div_ready   (div_ready),
        .div_by_zero (div_by_zero),
        .quotient    (quotient),
        .remainder   (remainder)
    );

    muldiv_writeback #(.XLEN(XLEN)) u_writeback (
        .instr       (instr),
        .op          (op),
        .is_illegal  (is_illegal),
        .sign_invert (sign_invert),
        .rs1_raw     (rs1_raw),
        .mul_ready   (mul_ready),
        .product     (product),
        .div_ready   (div_ready),
        .div_by_zero (div_by_zero),
        .quotient    (quotient),
        .remainder   (remainder),
        .ready       (ready),
        .illegal     (illegal),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_write    (rd_write)
    );

endmodule

`default_nettype wire

// File: muldiv_execute_assert.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_execute_assert
    import muldiv_pkg::*;
#(
    parameter int XLEN = 32
) (
    input logic      clk,
    input logic      rst_n,
    input logic      mul_req,
    input logic      div_req,
    input logic      ready,
    input logic      illegal,
    input reg_addr_t rd_addr,
    input logic      rd_write
);

    // Cycles an M instruction has been held without ready
    int unsigned wait_cnt;
    // Assertion failures so far
    int unsigned fail_cnt;

    initial fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (!rst_n || ready || !(mul_req || div_req)) begin
            wait_cnt <= 0;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) rd_write |-> ready)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_write without ready");
        end

    assert property (@(posedge clk) disable iff (!rst_n) rd_write |-> (rd_addr != '0))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_write to register zero");
        end

    assert property (@(posedge clk) disable iff (!rst_n) illegal |-> !rd_write)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_write on an illegal word");
        end

    assert property (@(posedge clk) disable iff (!rst_n) wait_cnt <= XLEN + 1)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ready missing for a held M instruction");
        end

endmodule

bind muldiv_execute muldiv_execute_assert #(.XLEN(XLEN)) u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .mul_req  (mul_req),
    .div_req  (div_req),
    .ready    (ready),
    .illegal  (illegal),
    .rd_addr  (rd_addr),
    .rd_write (rd_write)
);

`default_nettype wire

// File: tb_muldiv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module tb_muldiv_execute
    import muldiv_pkg::*;
();

    localparam int XLEN = 32;
    localparam int READY_TIMEOUT = 100;
    localparam logic [XLEN-1:0] MOST_NEG = 32'h8000_0000;
    // R-type fields as defined by the RISC-V spec
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] F7_MEXT = 7'b0000001;

    logic            clk;
    logic            rst_n;
    instr_t          instr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            ready;
    logic            illegal;
    reg_addr_t       rd_addr;
    logic [XLEN-1:0] rd_wdata;
    logic            rd_write;

    muldiv_execute #(.XLEN(XLEN)) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ready    (ready),
        .illegal  (illegal),
        .rd_addr  (rd_addr),
        .rd_wdata (rd_wdata),
        .rd_write (rd_write)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_wdata(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error: time %0t: %s rd_wdata 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_rd_addr(input reg_addr_t actual, input reg_addr_t expected,
                                 input string what);
        if (actual !== expected) begin
            $display("error: time %0t: %s rd_addr %0d, expected %0d",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("error: time %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Golden results in 64-bit arithmetic
    function automatic logic [XLEN-1:0] expected_result(input muldiv_op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (op)
            OP_MUL:    res = ua * ub;
            OP_MULH:   res = (sa * sb) >> 32;
            OP_MULHSU: res = (sa * $signed(ub)) >> 32;
            OP_MULHU:  res = (ua * ub) >> 32;
            OP_DIV:    res = sa / sb;
            OP_DIVU:   res = ua / ub;
            OP_REM:    res = sa % sb;
            default:   res = ua % ub;
        endcase
        if (b == '0) begin
            if (op inside {OP_DIV, OP_DIVU}) begin
                res = '1;
            end else if (op inside {OP_REM, OP_REMU}) begin
                res = ua;
            end
        end
        return res[XLEN-1:0];
    endfunction

    function automatic instr_t encode_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                        input reg_addr_t rd, input logic [6:0] opcode);
        return {funct7, 5'd2, 5'd1, funct3, rd, opcode};
    endfunction

    function automatic reg_addr_t random_rd();
        return reg_addr_t'($urandom_range(31, 1));
    endfunction

    task automatic wait_for_ready(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ready) begin
            cycles++;
            if (cycles >= READY_TIMEOUT) begin
                $display("timeout: ready did not arrive within %0d cycles for %s",
                         READY_TIMEOUT, what);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic run_op(input muldiv_op_e op, input reg_addr_t rd,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        string what;
        what = $sformatf("%s 0x%08h, 0x%08h", op.name(), a, b);
        @(posedge clk);
        instr    <= encode_r(F7_MEXT, op, rd, OPC_REG);
        rs1_data <= a;
        rs2_data <= b;
        wait_for_ready(what);
        check_flag(illegal, 1'b0, {what, " illegal"});
        check_rd_addr(rd_addr, rd, what);
        check_wdata(rd_wdata, expected_result(op, a, b), what);
        check_flag(rd_write, rd != '0, {what, " rd_write"});
    endtask

    task automatic run_illegal(input instr_t word);
        string what;
        what = $sformatf("word 0x%08h", word);
        @(posedge clk);
        instr <= word;
        // Illegal words complete with zero latency
        @(negedge clk);
        check_flag(ready, 1'b1, {what, " ready"});
        check_flag(illegal, 1'b1, {what, " illegal"});
        check_flag(rd_write, 1'b0, {what, " rd_write"});
    endtask

    task automatic test_multiply();
        logic [XLEN-1:0] corner [5];
        muldiv_op_e      op;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, MOST_NEG, 32'h7fff_ffff};
        for (int k = 0; k < 4; k++) begin
            op = muldiv_op_e'(3'(k));
            foreach (corner[i]) begin
                foreach (corner[j]) begin
                    run_op(op, random_rd(), corner[i], corner[j]);
                end
            end
            repeat (16) run_op(op, random_rd(), $urandom(), $urandom());
        end
    endtask

    task automatic test_divide();
        logic [XLEN-1:0] dividend [8];
        logic [XLEN-1:0] divisor [8];
        muldiv_op_e      op;
        dividend = '{32'd20, 32'hffff_ffec, 32'd20, 32'hffff_ffec,
                     32'd0, MOST_NEG, 32'hffff_ffff, 32'd5};
        divisor  = '{32'd6, 32'd6, 32'hffff_fffa, 32'hffff_fffa,
                     32'd5, 32'hffff_ffff, 32'd1, MOST_NEG};
        for (int k = 4; k < 8; k++) begin
            op = muldiv_op_e'(3'(k));
            foreach (dividend[i]) begin
                run_op(op, random_rd(), dividend[i], divisor[i]);
            end
            repeat (16) run_op(op, random_rd(), $urandom(), $urandom() >> $urandom_range(31, 0));
            // Divide by zero
            run_op(op, random_rd(), 32'h1234_5678, 32'h0);
            run_op(op, random_rd(), 32'hffff_fffb, 32'h0);
            run_op(op, random_rd(), 32'h0, 32'h0);
        end
    endtask

    task automatic test_rd_zero();
        run_op(OP_MUL, 5'd0, 32'd7, 32'd9);
        run_op(OP_REM, 5'd0, 32'hffff_ffec, 32'd6);
        run_op(OP_DIVU, 5'd0, 32'd11, 32'd0);
    endtask

    task automatic test_illegal_words();
        run_illegal(32'h0000_0013);
        run_illegal(encode_r(7'b0000000, 3'b000, 5'd3, OPC_REG));
        run_illegal(encode_r(7'b0100000, 3'b000, 5'd4, OPC_REG));
        run_illegal(encode_r(7'b0000011, 3'b100, 5'd6, OPC_REG));
        run_illegal(encode_r(F7_MEXT, 3'b100, 5'd5, 7'b0111011));
    endtask

    task automatic test_reset_mid_divide();
        @(posedge clk);
        instr    <= encode_r(F7_MEXT, OP_DIV, 5'd9, OPC_REG);
        rs1_data <= 32'h7654_3210;
        rs2_data <= 32'h0000_0013;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_flag(ready, 1'b0, "ready during divide");
        @(posedge clk);
        rst_n <= 1'b0;
        instr <= 32'h0000_0013;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // Divider has to start over from idle with the new operands
        run_op(OP_DIVU, 5'd11, 32'h0000_0064, 32'h0000_0007);
        run_op(OP_MUL, 5'd10, 32'h0001_2345, 32'h0006_789a);
    endtask

    initial begin
        void'($urandom(32'h7b90dfb9));
        rst_n    = 1'b0;
        instr    = 32'h0000_0013;
        rs1_data = '0;
        rs2_data = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_multiply();
        test_divide();
        test_rd_zero();
        test_illegal_words();
        test_reset_mid_divide();
        @(posedge clk);
        instr <= 32'h0000_0013;
        @(posedge clk);
        @(negedge clk);
        if (DUT.u_assert.fail_cnt != 0) begin
            $display("%0d bound assertions failed during the run", DUT.u_assert.fail_cnt);
            abort_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
muldiv_pkg.sv
muldiv_decode.sv
seq_multiplier.sv
seq_divider.sv
muldiv_writeback.sv
muldiv_execute.sv
muldiv_execute_assert.sv
tb_muldiv_execute.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_muldiv_execute
FILELIST = filelist.f
LOG      = sim.log
FAIL_MSG = *** FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
